// File: Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert
TOP   = tb_top
FLIST = tb.f
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/tb_clock.sv
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // falling edge after time zero so the async reset really fires
    initial begin
        rst_n = 1'b1;
        #1 rst_n = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule : tb_clock

`default_nettype wire

// File: bench/tb_memory.sv
`default_nettype none

module tb_memory (
    input  logic        clk,
    input  logic [31:0] instr_addr,
    output logic [31:0] instr,
    input  logic [31:0] addr_dm,
    input  logic        we_dm,
    input  logic [31:0] wd_dm,
    output logic [31:0] rd_dm
);

    // 64 words each, word addressed
    logic [31:0] rom [64];
    logic [31:0] ram [64];

    // pattern built from the whole word index
    initial begin
        for (int i = 0; i < 64; i++) begin
            ram[i] = {~i[15:0], i[15:0]};
        end
    end

    assign instr = rom[instr_addr[7:2]];
    assign rd_dm = ram[addr_dm[7:2]];

    always @(posedge clk) begin
        if (we_dm) begin
            ram[addr_dm[7:2]] <= wd_dm;
        end
    end

endmodule : tb_memory

`default_nettype wire

// File: bench/tb_top.sv
`default_nettype none

module tb_top;

    import rv_pkg::*;

    // 31 instructions with stalls only in the second half leave a wide margin
    localparam int timeout_cycles = 400;
    localparam int n_exp = 11;
    localparam logic [31:0] marker_a = 32'h0000_00f0;
    localparam logic [31:0] marker_b = 32'h0000_00f4;

    logic        clk;
    logic        rst_n;
    logic        cpu_en;
    logic [31:0] instr_addr;
    logic [31:0] instr;
    logic [31:0] addr_dm;
    logic        we_dm;
    logic [31:0] wd_dm;
    logic [31:0] rd_dm;
    logic [4:0]  reg_addr;
    logic [31:0] reg_data;

    logic [31:0] exp_addr [16];
    logic [31:0] exp_data [16];
    int          exp_idx;
    int          cycles;
    integer      seed;

    tb_clock i_clock (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    tb_memory i_mem (
        .clk        ( clk        ),
        .instr_addr ( instr_addr ),
        .instr      ( instr      ),
        .addr_dm    ( addr_dm    ),
        .we_dm      ( we_dm      ),
        .wd_dm      ( wd_dm      ),
        .rd_dm      ( rd_dm      )
    );

    rv_core #(
        .reset_vector ( 32'h0 )
    ) i_dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .cpu_en     ( cpu_en     ),
        .instr_addr ( instr_addr ),
        .instr      ( instr      ),
        .addr_dm    ( addr_dm    ),
        .we_dm      ( we_dm      ),
        .wd_dm      ( wd_dm      ),
        .rd_dm      ( rd_dm      ),
        .reg_addr   ( reg_addr   ),
        .reg_data   ( reg_data   )
    );

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, op_r};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input op_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, f3_word, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, op_lui};
    endfunction

    // program with the stores it must make written beside it
    initial begin
        for (int i = 0; i < 64; i++) begin
            i_mem.rom[i] = nop_instr;
        end
        i_mem.rom[0]  = i_type(12'd100, 5'd0, f3_add, 5'd1, op_i);
        i_mem.rom[1]  = u_type(20'h12345, 5'd2);
        i_mem.rom[2]  = i_type(12'hff9, 5'd0, f3_add, 5'd3, op_i);
        // write to x0 must be dropped
        i_mem.rom[3]  = i_type(12'd5, 5'd0, f3_add, 5'd0, op_i);
        i_mem.rom[4]  = s_type(12'h080, 5'd1, 5'd0);
        i_mem.rom[5]  = s_type(12'h084, 5'd2, 5'd0);
        i_mem.rom[6]  = r_type(7'd0, 5'd3, 5'd1, f3_add, 5'd4);
        i_mem.rom[7]  = r_type(f7_sub, 5'd3, 5'd1, f3_add, 5'd5);
        i_mem.rom[8]  = r_type(7'd0, 5'd3, 5'd1, f3_and, 5'd6);
        i_mem.rom[9]  = r_type(7'd0, 5'd1, 5'd2, f3_or, 5'd7);
        i_mem.rom[10] = i_type(12'd4, 5'd1, f3_sll, 5'd8, op_i);
        i_mem.rom[11] = s_type(12'h088, 5'd3, 5'd0);
        i_mem.rom[12] = s_type(12'h08c, 5'd4, 5'd0);
        i_mem.rom[13] = s_type(12'h090, 5'd5, 5'd0);
        i_mem.rom[14] = s_type(12'h094, 5'd6, 5'd0);
        i_mem.rom[15] = s_type(12'h098, 5'd7, 5'd0);
        i_mem.rom[16] = s_type(12'h09c, 5'd8, 5'd0);
        // ram word 16 holds 0xffef_0010
        i_mem.rom[17] = i_type(12'h040, 5'd0, f3_word, 5'd9, op_load);
        i_mem.rom[20] = i_type(12'h123, 5'd9, f3_add, 5'd10, op_i);
        i_mem.rom[23] = s_type(12'h0a0, 5'd10, 5'd0);
        i_mem.rom[24] = s_type(12'h0a4, 5'd0, 5'd0);
        // taken branch over both marker stores
        i_mem.rom[25] = b_type(13'd12, 5'd1, 5'd1, f3_beq);
        i_mem.rom[26] = s_type(marker_a[11:0], 5'd1, 5'd0);
        i_mem.rom[27] = s_type(marker_b[11:0], 5'd1, 5'd0);
        // not taken
        i_mem.rom[28] = b_type(13'd12, 5'd1, 5'd1, f3_bne);
        i_mem.rom[29] = s_type(12'h0a8, 5'd8, 5'd0);
        i_mem.rom[30] = b_type(13'd0, 5'd0, 5'd0, f3_beq);

        exp_addr[0]  = 32'h80;
        exp_data[0]  = 32'd100;
        exp_addr[1]  = 32'h84;
        exp_data[1]  = 32'h1234_5000;
        exp_addr[2]  = 32'h88;
        exp_data[2]  = 32'hffff_fff9;
        exp_addr[3]  = 32'h8c;
        exp_data[3]  = 32'd93;
        exp_addr[4]  = 32'h90;
        exp_data[4]  = 32'd107;
        exp_addr[5]  = 32'h94;
        exp_data[5]  = 32'h60;
        exp_addr[6]  = 32'h98;
        exp_data[6]  = 32'h1234_5064;
        exp_addr[7]  = 32'h9c;
        exp_data[7]  = 32'h640;
        exp_addr[8]  = 32'ha0;
        exp_data[8]  = 32'hffef_0133;
        exp_addr[9]  = 32'ha4;
        exp_data[9]  = 32'h0;
        exp_addr[10] = 32'ha8;
        exp_data[10] = 32'h640;
    end

    initial begin
        seed     = 32'ha1cdb576;
        cpu_en   = 1'b0;
        reg_addr = 5'd0;
        exp_idx  = 0;
        cycles   = 0;
    end

    // full speed until half the stores are out and random stalls after that
    always @(posedge clk) begin
        if (rst_n) begin
            if (exp_idx >= n_exp / 2) begin
                cpu_en <= (($random(seed) % 3) != 0) ? 1'b1 : 1'b0;
            end else begin
                cpu_en <= 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        if (rst_n && we_dm) begin
            exp_idx <= exp_idx + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == timeout_cycles) begin
            $display("timeout: the program did not reach its final store (%0d of %0d)",
                     exp_idx, n_exp);
            $display("Done: errors found");
            $fatal(1);
        end
    end

    a_reset_state : assert property (
        @(posedge clk) (!rst_n || $rose(rst_n)) |-> (instr_addr == 32'h0 && !we_dm)
    ) else begin
        $display("** Error at %0t: instr_addr = %h, we_dm = %b, expected 0 and 0",
                 $time, $sampled(instr_addr), $sampled(we_dm));
        $display("Done: errors found");
        $fatal(1);
    end

    a_store_count : assert property (
        @(posedge clk) disable iff (!rst_n) we_dm |-> (exp_idx < n_exp)
    ) else begin
        $display("a store happened after the whole expected list was written");
        $display("Done: errors found");
        $fatal(1);
    end

    a_store_addr : assert property (
        @(posedge clk) disable iff (!rst_n) (we_dm && exp_idx < n_exp) |->
            (addr_dm == exp_addr[exp_idx])
    ) else begin
        $display("** Error at %0t: addr_dm = %h, expected %h",
                 $time, $sampled(addr_dm), $sampled(exp_addr[exp_idx]));
        $display("Done: errors found");
        $fatal(1);
    end

    a_store_data : assert property (
        @(posedge clk) disable iff (!rst_n) (we_dm && exp_idx < n_exp) |->
            (wd_dm == exp_data[exp_idx])
    ) else begin
        $display("** Error at %0t: wd_dm = %h, expected %h",
                 $time, $sampled(wd_dm), $sampled(exp_data[exp_idx]));
        $display("Done: errors found");
        $fatal(1);
    end

    a_marker_free : assert property (
        @(posedge clk) disable iff (!rst_n) we_dm |->
            (addr_dm != marker_a && addr_dm != marker_b)
    ) else begin
        $display("a store skipped by the taken branch reached address %h", $sampled(addr_dm));
        $display("Done: errors found");
        $fatal(1);
    end

    a_stall_no_store : assert property (
        @(posedge clk) disable iff (!rst_n) !cpu_en |-> !we_dm
    ) else begin
        $display("** Error at %0t: we_dm = 1, expected 0 while cpu_en is low", $time);
        $display("Done: errors found");
        $fatal(1);
    end

    task automatic read_debug_reg(input logic [4:0] r, input logic [31:0] expected);
        @(posedge clk);
        reg_addr <= r;
        @(negedge clk);
        assert (reg_data == expected) else begin
            $display("** Error at %0t: reg_data (x%0d) = %h, expected %h",
                     $time, r, reg_data, expected);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    initial begin
        wait (exp_idx == n_exp);
        read_debug_reg(5'd0, 32'h0);
        read_debug_reg(5'd1, 32'd100);
        read_debug_reg(5'd2, 32'h1234_5000);
        read_debug_reg(5'd4, 32'd93);
        read_debug_reg(5'd9, 32'hffef_0010);
        read_debug_reg(5'd10, 32'hffef_0133);
        $display("Done: no errors");
        $finish;
    end

endmodule : tb_top

`default_nettype wire

// File: rtl/rv_core.sv
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_en,
    output logic [rv_pkg::xlen-1:0] instr_addr,
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] addr_dm,
    output logic                    we_dm,
    output logic [rv_pkg::xlen-1:0] wd_dm,
    input  logic [rv_pkg::xlen-1:0] rd_dm,
    input  logic [4:0]              reg_addr,
    output logic [rv_pkg::xlen-1:0] reg_data
);

    import rv_pkg::*;

    // fetch to decode, execute back to fetch
    logic [xlen-1:0] id_instr;
    logic [xlen-1:0] id_pc;
    logic            branch_taken;
    logic [xlen-1:0] branch_target;
    // decode to execute
    logic [xlen-1:0] ex_rs1;
    logic [xlen-1:0] ex_rs2;
    logic [xlen-1:0] ex_imm;
    logic [xlen-1:0] ex_pc;
    alu_op_t         ex_alu_op;
    logic            ex_use_imm;
    logic            ex_branch;
    logic            ex_bne;
    logic            ex_we_rf;
    logic            ex_we_dm;
    logic            ex_load;
    logic [4:0]      ex_rd;
    // execute to memory
    logic [xlen-1:0] mem_result;
    logic [xlen-1:0] mem_store_data;
    logic            mem_we_rf;
    logic            mem_we_dm;
    logic            mem_load;
    logic [4:0]      mem_rd;
    // write-back into the register file
    logic            wb_we;
    logic [4:0]      wb_addr;
    logic [xlen-1:0] wb_data;

    rv_fetch #(
        .reset_vector ( reset_vector )
    ) i_fetch (
        .clk           ( clk           ),
        .rst_n         ( rst_n         ),
        .cpu_en        ( cpu_en        ),
        .branch_taken  ( branch_taken  ),
        .branch_target ( branch_target ),
        .instr         ( instr         ),
        .instr_addr    ( instr_addr    ),
        .id_instr      ( id_instr      ),
        .id_pc         ( id_pc         )
    );

    rv_decode i_decode (
        .clk        ( clk          ),
        .rst_n      ( rst_n        ),
        .cpu_en     ( cpu_en       ),
        .flush      ( branch_taken ),
        .id_instr   ( id_instr     ),
        .id_pc      ( id_pc        ),
        .wb_we      ( wb_we        ),
        .wb_addr    ( wb_addr      ),
        .wb_data    ( wb_data      ),
        .reg_addr   ( reg_addr     ),
        .reg_data   ( reg_data     ),
        .ex_rs1     ( ex_rs1       ),
        .ex_rs2     ( ex_rs2       ),
        .ex_imm     ( ex_imm       ),
        .ex_pc      ( ex_pc        ),
        .ex_alu_op  ( ex_alu_op    ),
        .ex_use_imm ( ex_use_imm   ),
        .ex_branch  ( ex_branch    ),
        .ex_bne     ( ex_bne       ),
        .ex_we_rf   ( ex_we_rf     ),
        .ex_we_dm   ( ex_we_dm     ),
        .ex_load    ( ex_load      ),
        .ex_rd      ( ex_rd        )
    );

    rv_execute i_execute (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .cpu_en         ( cpu_en         ),
        .ex_rs1         ( ex_rs1         ),
        .ex_rs2         ( ex_rs2         ),
        .ex_imm         ( ex_imm         ),
        .ex_pc          ( ex_pc          ),
        .ex_alu_op      ( ex_alu_op      ),
        .ex_use_imm     ( ex_use_imm     ),
        .ex_branch      ( ex_branch      ),
        .ex_bne         ( ex_bne         ),
        .ex_we_rf       ( ex_we_rf       ),
        .ex_we_dm       ( ex_we_dm       ),
        .ex_load        ( ex_load        ),
        .ex_rd          ( ex_rd          ),
        .branch_taken   ( branch_taken   ),
        .branch_target  ( branch_target  ),
        .mem_result     ( mem_result     ),
        .mem_store_data ( mem_store_data ),
        .mem_we_rf      ( mem_we_rf      ),
        .mem_we_dm      ( mem_we_dm      ),
        .mem_load       ( mem_load       ),
        .mem_rd         ( mem_rd         )
    );

    rv_mem_wb i_mem_wb (
        .clk            ( clk            ),
        .rst_n          ( rst_n          ),
        .cpu_en         ( cpu_en         ),
        .mem_result     ( mem_result     ),
        .mem_store_data ( mem_store_data ),
        .mem_we_rf      ( mem_we_rf      ),
        .mem_we_dm      ( mem_we_dm      ),
        .mem_load       ( mem_load       ),
        .mem_rd         ( mem_rd         ),
        .rd_dm          ( rd_dm          ),
        .addr_dm        ( addr_dm        ),
        .wd_dm          ( wd_dm          ),
        .we_dm          ( we_dm          ),
        .wb_we          ( wb_we          ),
        .wb_addr        ( wb_addr        ),
        .wb_data        ( wb_data        )
    );

endmodule : rv_core

`default_nettype wire

// File: rtl/rv_decode.sv
`default_nettype none

module rv_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_en,
    input  logic                    flush,
    input  logic [rv_pkg::xlen-1:0] id_instr,
    input  logic [rv_pkg::xlen-1:0] id_pc,
    input  logic                    wb_we,
    input  logic [4:0]              wb_addr,
    input  logic [rv_pkg::xlen-1:0] wb_data,
    input  logic [4:0]              reg_addr,
    output logic [rv_pkg::xlen-1:0] reg_data,
    output logic [rv_pkg::xlen-1:0] ex_rs1,
    output logic [rv_pkg::xlen-1:0] ex_rs2,
    output logic [rv_pkg::xlen-1:0] ex_imm,
    output logic [rv_pkg::xlen-1:0] ex_pc,
    output rv_pkg::alu_op_t         ex_alu_op,
    output logic                    ex_use_imm,
    output logic                    ex_branch,
    output logic                    ex_bne,
    output logic                    ex_we_rf,
    output logic                    ex_we_dm,
    output logic                    ex_load,
    output logic [4:0]              ex_rd
);

    import rv_pkg::*;

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1_addr;
    logic [4:0]      rs2_addr;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic [xlen-1:0] imm;
    alu_op_t         alu_op;
    logic            use_imm;
    logic            branch;
    logic            we_rf;
    logic            we_dm;
    logic            load;

    assign opcode   = id_instr[6:0];
    assign rd_addr  = id_instr[11:7];
    assign funct3   = id_instr[14:12];
    assign rs1_addr = id_instr[19:15];
    assign rs2_addr = id_instr[24:20];
    assign funct7   = id_instr[31:25];

    rv_reg_file i_reg_file (
        .clk      ( clk      ),
        .ra1      ( rs1_addr ),
        .ra2      ( rs2_addr ),
        .rd1      ( rs1_data ),
        .rd2      ( rs2_data ),
        .we       ( wb_we    ),
        .wa       ( wb_addr  ),
        .wd       ( wb_data  ),
        .reg_addr ( reg_addr ),
        .reg_data ( reg_data )
    );

    always_comb begin
        alu_op  = alu_add;
        use_imm = 1'b0;
        branch  = 1'b0;
        we_rf   = 1'b0;
        we_dm   = 1'b0;
        load    = 1'b0;
        // I format unless the opcode says otherwise
        imm     = {{20{id_instr[31]}}, id_instr[31:20]};
        case (opcode)
            op_r: begin
                we_rf = 1'b1;
                case (funct3)
                    f3_add:  alu_op = (funct7 == f7_sub) ? alu_sub : alu_add;
                    f3_or:   alu_op = alu_or;
                    f3_and:  alu_op = alu_and;
                    default: we_rf = 1'b0;
                endcase
            end
            op_i: begin
                use_imm = 1'b1;
                we_rf   = (funct3 == f3_add) || (funct3 == f3_sll);
                alu_op  = (funct3 == f3_sll) ? alu_sll : alu_add;
            end
            op_lui: begin
                use_imm = 1'b1;
                we_rf   = 1'b1;
                alu_op  = alu_passb;
                imm     = {id_instr[31:12], 12'b0};
            end
            op_load: begin
                use_imm = 1'b1;
                we_rf   = (funct3 == f3_word);
                load    = (funct3 == f3_word);
            end
            op_store: begin
                use_imm = 1'b1;
                we_dm   = (funct3 == f3_word);
                imm     = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
            end
            op_branch: begin
                branch = (funct3 == f3_beq) || (funct3 == f3_bne);
                imm    = {{19{id_instr[31]}}, id_instr[31], id_instr[7],
                          id_instr[30:25], id_instr[11:8], 1'b0};
            end
            default: ;
        endcase
    end

    // control half of the decode/execute register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_branch <= 1'b0;
            ex_we_rf  <= 1'b0;
            ex_we_dm  <= 1'b0;
            ex_load   <= 1'b0;
        end else if (cpu_en) begin
            ex_branch <= branch && !flush;
            ex_we_rf  <= we_rf && !flush;
            ex_we_dm  <= we_dm && !flush;
            ex_load   <= load && !flush;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            ex_rs1     <= rs1_data;
            ex_rs2     <= rs2_data;
            ex_imm     <= imm;
            ex_pc      <= id_pc;
            ex_alu_op  <= alu_op;
            ex_use_imm <= use_imm;
            ex_bne     <= (funct3 == f3_bne);
            ex_rd      <= rd_addr;
        end
    end

endmodule : rv_decode

`default_nettype wire

// File: rtl/rv_execute.sv
`default_nettype none

module rv_execute (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_en,
    input  logic [rv_pkg::xlen-1:0] ex_rs1,
    input  logic [rv_pkg::xlen-1:0] ex_rs2,
    input  logic [rv_pkg::xlen-1:0] ex_imm,
    input  logic [rv_pkg::xlen-1:0] ex_pc,
    input  rv_pkg::alu_op_t         ex_alu_op,
    input  logic                    ex_use_imm,
    input  logic                    ex_branch,
    input  logic                    ex_bne,
    input  logic                    ex_we_rf,
    input  logic                    ex_we_dm,
    input  logic                    ex_load,
    input  logic [4:0]              ex_rd,
    output logic                    branch_taken,
    output logic [rv_pkg::xlen-1:0] branch_target,
    output logic [rv_pkg::xlen-1:0] mem_result,
    output logic [rv_pkg::xlen-1:0] mem_store_data,
    output logic                    mem_we_rf,
    output logic                    mem_we_dm,
    output logic                    mem_load,
    output logic [4:0]              mem_rd
);

    import rv_pkg::*;

    logic [xlen-1:0] src_b;
    logic [xlen-1:0] result;
    logic            equal;

    assign src_b = ex_use_imm ? ex_imm : ex_rs2;

    always_comb begin
        case (ex_alu_op)
            alu_sub:   result = ex_rs1 - src_b;
            alu_and:   result = ex_rs1 & src_b;
            alu_or:    result = ex_rs1 | src_b;
            // shamt sits in the low immediate bits
            alu_sll:   result = ex_rs1 << ex_imm[4:0];
            alu_passb: result = src_b;
            default:   result = ex_rs1 + src_b;
        endcase
    end

    // beq and bne compare the two registers directly
    assign equal         = (ex_rs1 == ex_rs2);
    assign branch_taken  = ex_branch && (ex_bne ? !equal : equal);
    assign branch_target = ex_pc + ex_imm;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_we_rf <= 1'b0;
            mem_we_dm <= 1'b0;
            mem_load  <= 1'b0;
        end else if (cpu_en) begin
            mem_we_rf <= ex_we_rf;
            mem_we_dm <= ex_we_dm;
            mem_load  <= ex_load;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            mem_result     <= result;
            mem_store_data <= ex_rs2;
            mem_rd         <= ex_rd;
        end
    end

    a_target_aligned : assert property (
        @(posedge clk) disable iff (!rst_n) branch_taken |-> (branch_target[1:0] == 2'b00)
    );

endmodule : rv_execute

`default_nettype wire

// File: rtl/rv_fetch.sv
`default_nettype none

module rv_fetch #(
    parameter logic [rv_pkg::xlen-1:0] reset_vector = '0
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_en,
    input  logic                    branch_taken,
    input  logic [rv_pkg::xlen-1:0] branch_target,
    input  logic [rv_pkg::xlen-1:0] instr,
    output logic [rv_pkg::xlen-1:0] instr_addr,
    output logic [rv_pkg::xlen-1:0] id_instr,
    output logic [rv_pkg::xlen-1:0] id_pc
);

    import rv_pkg::*;

    logic [xlen-1:0] pc_next;

    // redirect wins over the sequential address
    assign pc_next = branch_taken ? branch_target : instr_addr + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            instr_addr <= reset_vector;
            id_instr   <= nop_instr;
            id_pc      <= reset_vector;
        end else if (cpu_en) begin
            instr_addr <= pc_next;
            // the word in the fetch slot is younger than the branch
            id_instr   <= branch_taken ? nop_instr : instr;
            id_pc      <= instr_addr;
        end
    end

    a_pc_aligned : assert property (
        @(posedge clk) disable iff (!rst_n) instr_addr[1:0] == 2'b00
    );

endmodule : rv_fetch

`default_nettype wire

// File: rtl/rv_mem_wb.sv
`default_nettype none

module rv_mem_wb (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cpu_en,
    input  logic [rv_pkg::xlen-1:0] mem_result,
    input  logic [rv_pkg::xlen-1:0] mem_store_data,
    input  logic                    mem_we_rf,
    input  logic                    mem_we_dm,
    input  logic                    mem_load,
    input  logic [4:0]              mem_rd,
    input  logic [rv_pkg::xlen-1:0] rd_dm,
    output logic [rv_pkg::xlen-1:0] addr_dm,
    output logic [rv_pkg::xlen-1:0] wd_dm,
    output logic                    we_dm,
    output logic                    wb_we,
    output logic [4:0]              wb_addr,
    output logic [rv_pkg::xlen-1:0] wb_data
);

    logic wb_we_r;

    assign addr_dm = mem_result;
    assign wd_dm   = mem_store_data;
    // a stalled store must not repeat
    assign we_dm   = mem_we_dm && cpu_en;
    assign wb_we   = wb_we_r && cpu_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_we_r <= 1'b0;
        end else if (cpu_en) begin
            wb_we_r <= mem_we_rf;
        end
    end

    always_ff @(posedge clk) begin
        if (cpu_en) begin
            wb_addr <= mem_rd;
            wb_data <= mem_load ? rd_dm : mem_result;
        end
    end

endmodule : rv_mem_wb

`default_nettype wire

// File: rtl/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen = 32;

    // base opcodes of the supported subset
    typedef enum logic [6:0] {
        op_r      = 7'b0110011,
        op_i      = 7'b0010011,
        op_lui    = 7'b0110111,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_branch = 7'b1100011
    } op_t;

    // funct3 values
    localparam logic [2:0] f3_add  = 3'b000;
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_word = 3'b010;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;

    // funct7 for sub, zero for everything else
    localparam logic [6:0] f7_sub  = 7'b0100000;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_sll,
        alu_passb
    } alu_op_t;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nop_instr = 32'h0000_0013;

endpackage : rv_pkg

`default_nettype wire

// File: rtl/rv_reg_file.sv
`default_nettype none

module rv_reg_file (
    input  logic                    clk,
    input  logic [4:0]              ra1,
    input  logic [4:0]              ra2,
    output logic [rv_pkg::xlen-1:0] rd1,
    output logic [rv_pkg::xlen-1:0] rd2,
    input  logic                    we,
    input  logic [4:0]              wa,
    input  logic [rv_pkg::xlen-1:0] wd,
    input  logic [4:0]              reg_addr,
    output logic [rv_pkg::xlen-1:0] reg_data
);

    import rv_pkg::*;

    logic [xlen-1:0] regs [32];

    // x0 reads zero and a same-cycle write is passed through
    function automatic logic [xlen-1:0] read_port(input logic [4:0] ra);
        if (ra == 5'd0) begin
            return '0;
        end else if (we && (wa == ra)) begin
            return wd;
        end
        return regs[ra];
    endfunction

    always_ff @(posedge clk) begin
        if (we && (wa != 5'd0)) begin
            regs[wa] <= wd;
        end
    end

    always_comb rd1      = read_port(ra1);
    always_comb rd2      = read_port(ra2);
    always_comb reg_data = read_port(reg_addr);

endmodule : rv_reg_file

`default_nettype wire

// File: tb.f
rtl/rv_pkg.sv
rtl/rv_fetch.sv
rtl/rv_reg_file.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_mem_wb.sv
rtl/rv_core.sv
bench/tb_clock.sv
bench/tb_memory.sv
bench/tb_top.sv
